// ==== flist.f ====
verilog/axi_lite_pkg.sv
verilog/clint_pkg.sv
verilog/clint_axi_slave.sv
verilog/clint_regs.sv
verilog/clint_timer.sv
verilog/clint_top.sv
testbench/clint_properties.sv
testbench/clint_tb.sv

// ==== testbench/clint_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_properties (
    input logic                  clk,
    input logic                  rst_n,
    input axi_lite_pkg::axi_aw_t aw,
    input logic                  awvalid,
    input logic                  awready,
    input axi_lite_pkg::axi_w_t  w,
    input logic                  wvalid,
    input logic                  wready,
    input axi_lite_pkg::axi_b_t  b,
    input logic                  bvalid,
    input logic                  bready,
    input axi_lite_pkg::axi_ar_t ar,
    input logic                  arvalid,
    input logic                  arready,
    input axi_lite_pkg::axi_r_t  r,
    input logic                  rvalid,
    input logic                  rready
);

    // master side holds valid and payload until ready
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("aw channel changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("w channel changed before wready");

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("ar channel changed before arready");

    // slave side holds responses under back-pressure
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(b))
        else $error("b channel changed before bready");

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(r))
        else $error("r channel changed before rready");

    // both readies pulse together, one cycle after aw and w are both present
    aw_w_ready: assert property (@(posedge clk) disable iff (!rst_n)
        awready || wready |->
            awready && wready && $past(awvalid && wvalid && !awready && !bvalid))
        else $error("awready and wready not raised together after both channels");

endmodule

bind clint_axi_slave clint_properties u_props (.*);

`default_nettype wire

// ==== testbench/clint_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_tb;
    import axi_lite_pkg::*;
    import clint_pkg::*;

    localparam int CLK_HALF   = 4;
    localparam int RESET_CYC  = 3;
    localparam int CYC_PER_OP = 40;
    localparam int HS_LIMIT   = 16;

    // one line of the vector file
    typedef struct packed {
        logic [7:0]  op;
        logic [15:0] offset;
        logic [63:0] wdata;
        logic [7:0]  strb;
        logic [63:0] exp_data;
        logic [1:0]  exp_resp;
        logic [7:0]  tol;
        logic        exp_mtip;
        logic        exp_msip;
        logic [7:0]  stall;
    } vec_t;

    logic        clk;
    logic        rst_n;
    axi_aw_t     aw;
    logic        awvalid;
    logic        awready;
    axi_w_t      w;
    logic        wvalid;
    logic        wready;
    axi_b_t      b;
    logic        bvalid;
    logic        bready;
    axi_ar_t     ar;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready;
    logic        mtip;
    logic        msip;

    vec_t        vectors[$];
    int          errors;
    int          passed;
    int unsigned cycles;
    int unsigned cycle_limit;
    int unsigned mtime_wr_cycle;
    logic [63:0] got_data;
    axi_resp_t   got_resp;

    clint_top uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .mtip    (mtip),
        .msip    (msip)
    );

    always #CLK_HALF clk = ~clk;

    // limit is set once the vectors are loaded
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic load_vectors(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [15:0] off;
        logic [63:0] wd;
        logic [63:0] ed;
        logic [7:0]  sb;
        logic [1:0]  er;
        int          tol;
        int          mt;
        int          ms;
        int          st;
        ok = 1'b0;
        fd = $fopen("testbench/clint_tests.txt", "r");
        if (fd != 0)
        begin
            ok = 1'b1;
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                // skip blank lines and comment lines
                if (n > 0 && line.len() > 1 && line.getc(0) != "#")
                begin
                    n = $sscanf(line, "%s %h %h %h %h %h %d %d %d %d",
                                op, off, wd, sb, ed, er, tol, mt, ms, st);
                    assert (n == 10)
                    else
                    begin
                        $display("malformed vector line: %s", line);
                        errors++;
                    end
                    if (n == 10)
                    begin
                        vectors.push_back('{op, off, wd, sb, ed, er, tol[7:0], mt[0], ms[0],
                                            st[7:0]});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // aw and w together, then the b response with optional bready hold-off
    task automatic axi_write(input vec_t v, output axi_resp_t resp);
        int waited;
        resp    = RESP_DECERR;
        aw.addr = v.offset;
        w.data  = v.wdata;
        w.strb  = v.strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (v.stall == 0);
        waited  = 0;
        @(negedge clk);
        while (!awready && waited < HS_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        assert (awready)
        else
        begin
            $display("write to offset %h was never accepted", v.offset);
            errors++;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waited  = 0;
        while (!bvalid && waited < HS_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        assert (bvalid)
        else
        begin
            $display("write response for offset %h never arrived", v.offset);
            errors++;
        end
        repeat (v.stall) @(negedge clk);
        bready = 1'b1;
        resp   = b.resp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    // ar, then the r response with optional rready hold-off
    task automatic axi_read(input vec_t v, output logic [63:0] data, output axi_resp_t resp);
        int waited;
        data    = '0;
        resp    = RESP_DECERR;
        ar.addr = v.offset;
        arvalid = 1'b1;
        rready  = (v.stall == 0);
        waited  = 0;
        @(negedge clk);
        while (!arready && waited < HS_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        assert (arready)
        else
        begin
            $display("read of offset %h was never accepted", v.offset);
            errors++;
        end
        @(negedge clk);
        arvalid = 1'b0;
        waited  = 0;
        while (!rvalid && waited < HS_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        assert (rvalid)
        else
        begin
            $display("read data for offset %h never arrived", v.offset);
            errors++;
        end
        repeat (v.stall) @(negedge clk);
        rready = 1'b1;
        data   = r.data;
        resp   = r.resp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    initial
    begin
        bit          ok;
        vec_t        v;
        int          errs_before;
        int unsigned span;
        int unsigned rd_start;
        int unsigned lead;
        clk            = 1'b0;
        rst_n          = 1'b0;
        aw             = '0;
        awvalid        = 1'b0;
        w              = '0;
        wvalid         = 1'b0;
        bready         = 1'b0;
        ar             = '0;
        arvalid        = 1'b0;
        rready         = 1'b0;
        errors         = 0;
        passed         = 0;
        cycles         = 0;
        cycle_limit    = 0;
        mtime_wr_cycle = 0;
        load_vectors(ok);
        if (!ok)
        begin
            $display("could not open testbench/clint_tests.txt");
            $display("SOME TESTS FAILED");
            $finish;
        end
        else
        begin
            cycle_limit = vectors.size() * CYC_PER_OP + RESET_CYC;
            repeat (RESET_CYC) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            foreach (vectors[i])
            begin
                v           = vectors[i];
                errs_before = errors;
                if (v.op == "w")
                begin
                    // counter window for later mtime reads starts here
                    if (v.offset == MTIME_OFFSET)
                    begin
                        mtime_wr_cycle = cycles;
                    end
                    axi_write(v, got_resp);
                    assert (got_resp == v.exp_resp)
                    else
                    begin
                        $display("FAIL %0t bresp expected %0d got %0d", $time, v.exp_resp,
                                 got_resp);
                        errors++;
                    end
                end
                else if (v.op == "r")
                begin
                    rd_start = cycles;
                    axi_read(v, got_data, got_resp);
                    assert (got_resp == v.exp_resp)
                    else
                    begin
                        $display("FAIL %0t rresp expected %0d got %0d", $time, v.exp_resp,
                                 got_resp);
                        errors++;
                    end
                    span = cycles - mtime_wr_cycle;
                    if (v.tol != 0)
                    begin
                        // write and read accepts both trail their request by two cycles
                        lead = rd_start - mtime_wr_cycle - 1;
                        assert (got_data >= v.exp_data + 64'(lead) &&
                                got_data <= v.exp_data + 64'(span))
                        else
                        begin
                            $display("FAIL %0t rdata expected %h..%h got %h", $time,
                                     v.exp_data + 64'(lead), v.exp_data + 64'(span),
                                     got_data);
                            errors++;
                        end
                    end
                    else
                    begin
                        assert (got_data == v.exp_data)
                        else
                        begin
                            $display("FAIL %0t rdata expected %h got %h", $time, v.exp_data,
                                     got_data);
                            errors++;
                        end
                    end
                end
                else
                begin
                    repeat (v.stall) @(negedge clk);
                end
                assert (mtip == v.exp_mtip)
                else
                begin
                    $display("FAIL %0t mtip expected %0d got %0d", $time, v.exp_mtip, mtip);
                    errors++;
                end
                assert (msip == v.exp_msip)
                else
                begin
                    $display("FAIL %0t msip expected %0d got %0d", $time, v.exp_msip, msip);
                    errors++;
                end
                if (errors == errs_before)
                begin
                    passed++;
                end
                $display("test %0d %s offset %h: %s", i + 1, v.op, v.offset,
                         (errors == errs_before) ? "ok" : "failed");
            end
            $display("%0d tests, %0d passed, %0d failed, %0d check errors", vectors.size(),
                     passed, vectors.size() - passed, errors);
            if (errors == 0)
            begin
                $display("ALL TESTS PASSED");
            end
            else
            begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/clint_tests.txt ====
# op offset wdata strb exp_rdata exp_resp tol exp_mtip exp_msip stall
# op is w, r or t; tol 1 checks an mtime read against counted cycles; stall is wait or hold cycles
r 0000 0000000000000000 00 0000000000000000 0 0 0 0 0
r 4000 0000000000000000 00 ffffffffffffffff 0 0 0 0 0
w 4000 1122334455667788 0f 0000000000000000 0 0 0 0 0
r 4000 0000000000000000 00 ffffffff55667788 0 0 0 0 0
w 4000 aabbccddeeff0011 a0 0000000000000000 0 0 0 0 0
r 4000 0000000000000000 00 aaffccff55667788 0 0 0 0 0
w bff8 0000000000001000 ff 0000000000000000 0 0 0 0 0
r bff8 0000000000000000 00 0000000000001000 0 1 0 0 0
t 0000 0000000000000000 00 0000000000000000 0 0 0 0 10
r bff8 0000000000000000 00 0000000000001000 0 1 0 0 0
w 4000 0000000000000800 ff 0000000000000000 0 0 1 0 0
r 4000 0000000000000000 00 0000000000000800 0 0 1 0 0
w 4000 ffffffffffffffff ff 0000000000000000 0 0 0 0 0
w 0000 0000000000000001 01 0000000000000000 0 0 0 1 0
r 0000 0000000000000000 00 0000000000000001 0 0 0 1 0
w 0000 0000000000000000 01 0000000000000000 0 0 0 0 0
r 0000 0000000000000000 00 0000000000000000 0 0 0 0 0
w 0008 00000000deadbeef ff 0000000000000000 3 0 0 0 3
r 1000 0000000000000000 00 0000000000000000 3 0 0 0 4
w bff0 0123456789abcdef ff 0000000000000000 3 0 0 0 2
r bff0 0000000000000000 00 0000000000000000 3 0 0 0 2
r 4000 0000000000000000 00 ffffffffffffffff 0 0 0 0 2
r 0000 0000000000000000 00 0000000000000000 0 0 0 0 3
r bff8 0000000000000000 00 0000000000001000 0 1 0 0 0

// ==== verilog/axi_lite_pkg.sv ====
`default_nettype none

package axi_lite_pkg;

    // bus geometry
    localparam int AXI_DATA_W = 64;
    localparam int AXI_ADDR_W = 16;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_DECERR = 2'b11;

    // write address channel
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
    } axi_aw_t;

    // write data channel
    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
    } axi_w_t;

    // read address channel
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
    } axi_ar_t;

    // read data channel
    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        axi_resp_t             resp;
    } axi_r_t;

    // write response channel
    typedef struct packed {
        axi_resp_t resp;
    } axi_b_t;

endpackage

`default_nettype wire

// ==== verilog/clint_axi_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_axi_slave (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_lite_pkg::axi_aw_t  aw,
    input  logic                   awvalid,
    output logic                   awready,
    input  axi_lite_pkg::axi_w_t   w,
    input  logic                   wvalid,
    output logic                   wready,
    output axi_lite_pkg::axi_b_t   b,
    output logic                   bvalid,
    input  logic                   bready,
    input  axi_lite_pkg::axi_ar_t  ar,
    input  logic                   arvalid,
    output logic                   arready,
    output axi_lite_pkg::axi_r_t   r,
    output logic                   rvalid,
    input  logic                   rready,
    output clint_pkg::reg_wr_t     reg_wr,
    input  logic                   wr_hit,
    output clint_pkg::reg_rd_t     reg_rd,
    input  clint_pkg::reg_rd_rsp_t rd_rsp
);
    import axi_lite_pkg::*;

    logic   wr_ready_q;
    logic   wr_accept;
    logic   bvalid_q;
    axi_b_t b_q;

    logic   ar_ready_q;
    logic   rd_accept;
    logic   rvalid_q;
    axi_r_t r_q;

    // aw and w are taken together, so one ready serves both channels
    assign awready   = wr_ready_q;
    assign wready    = wr_ready_q;
    assign wr_accept = wr_ready_q & awvalid & wvalid;

    // ready only after both channels are present and no response waits
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ready_q <= 1'b0;
        end
        else
        begin
            wr_ready_q <= awvalid & wvalid & ~wr_ready_q & ~bvalid_q;
        end
    end

    // register write goes out in the accept cycle
    always_comb
    begin
        reg_wr.en   = wr_accept;
        reg_wr.addr = aw.addr;
        reg_wr.data = w.data;
        reg_wr.strb = w.strb;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bvalid_q <= 1'b0;
        end
        else if (wr_accept)
        begin
            bvalid_q <= 1'b1;
        end
        else if (bready)
        begin
            bvalid_q <= 1'b0;
        end
    end

    // decode result comes back from the register block in the accept cycle
    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            b_q.resp <= wr_hit ? RESP_OKAY : RESP_DECERR;
        end
    end

    assign bvalid = bvalid_q;
    assign b      = b_q;

    // read side, one transaction at a time
    assign arready   = ar_ready_q;
    assign rd_accept = ar_ready_q & arvalid;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ar_ready_q <= 1'b0;
        end
        else
        begin
            ar_ready_q <= arvalid & ~ar_ready_q & ~rvalid_q;
        end
    end

    always_comb
    begin
        reg_rd.en   = rd_accept;
        reg_rd.addr = ar.addr;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rvalid_q <= 1'b0;
        end
        else if (rd_accept)
        begin
            rvalid_q <= 1'b1;
        end
        else if (rready)
        begin
            rvalid_q <= 1'b0;
        end
    end

    // capture read data and hold it until rready
    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            r_q.data <= rd_rsp.data;
            r_q.resp <= rd_rsp.hit ? RESP_OKAY : RESP_DECERR;
        end
    end

    assign rvalid = rvalid_q;
    assign r      = r_q;

endmodule

`default_nettype wire

// ==== verilog/clint_pkg.sv ====
`default_nettype none

package clint_pkg;

    // register offsets share the bus address width
    localparam int REG_ADDR_W = axi_lite_pkg::AXI_ADDR_W;
    localparam int MTIME_W    = 64;
    localparam int REG_STRB_W = MTIME_W / 8;

    localparam logic [REG_ADDR_W-1:0] MSIP_OFFSET     = 16'h0000;
    localparam logic [REG_ADDR_W-1:0] MTIMECMP_OFFSET = 16'h4000;
    localparam logic [REG_ADDR_W-1:0] MTIME_OFFSET    = 16'hBFF8;

    // one register write, valid for a single cycle
    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [MTIME_W-1:0]    data;
        logic [REG_STRB_W-1:0] strb;
    } reg_wr_t;

    // one register read, valid for a single cycle
    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
    } reg_rd_t;

    // hit is low for an unmapped offset
    typedef struct packed {
        logic [MTIME_W-1:0] data;
        logic               hit;
    } reg_rd_rsp_t;

    // bytewise merge of new data into an old value under strobes
    function automatic logic [MTIME_W-1:0] merge_bytes(
        input logic [MTIME_W-1:0]    old_val,
        input logic [MTIME_W-1:0]    new_val,
        input logic [REG_STRB_W-1:0] strb
    );
        logic [MTIME_W-1:0] result;
        result = old_val;
        for (int i = 0; i < REG_STRB_W; i++) begin
            if (strb[i])
            begin
                result[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/clint_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  clint_pkg::reg_wr_t            reg_wr,
    output logic                          wr_hit,
    input  clint_pkg::reg_rd_t            reg_rd,
    output clint_pkg::reg_rd_rsp_t        rd_rsp,
    input  logic [clint_pkg::MTIME_W-1:0] mtime,
    output clint_pkg::reg_wr_t            mtime_wr,
    output logic [clint_pkg::MTIME_W-1:0] mtimecmp,
    output logic                          msip
);
    import clint_pkg::*;

    logic               wr_sel_msip;
    logic               wr_sel_mtimecmp;
    logic               wr_sel_mtime;
    logic               msip_q;
    logic [MTIME_W-1:0] mtimecmp_q;

    // write address decode
    always_comb
    begin
        wr_sel_msip     = (reg_wr.addr == MSIP_OFFSET);
        wr_sel_mtimecmp = (reg_wr.addr == MTIMECMP_OFFSET);
        wr_sel_mtime    = (reg_wr.addr == MTIME_OFFSET);
        wr_hit          = wr_sel_msip | wr_sel_mtimecmp | wr_sel_mtime;
    end

    // only bit 0 of msip is implemented
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            msip_q <= 1'b0;
        end
        else if (reg_wr.en && wr_sel_msip && reg_wr.strb[0])
        begin
            msip_q <= reg_wr.data[0];
        end
    end

    // all ones from reset keeps the timer interrupt quiet
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtimecmp_q <= '1;
        end
        else if (reg_wr.en && wr_sel_mtimecmp)
        begin
            mtimecmp_q <= merge_bytes(mtimecmp_q, reg_wr.data, reg_wr.strb);
        end
    end

    // the counter itself lives in the timer, pass the write across
    always_comb
    begin
        mtime_wr    = reg_wr;
        mtime_wr.en = reg_wr.en & wr_sel_mtime;
    end

    // read mux, unmapped offsets give zero with hit low
    always_comb
    begin
        rd_rsp = '0;
        if (reg_rd.en)
        begin
            case (reg_rd.addr)
                MSIP_OFFSET:
                begin
                    rd_rsp.data = {{(MTIME_W-1){1'b0}}, msip_q};
                    rd_rsp.hit  = 1'b1;
                end
                MTIMECMP_OFFSET:
                begin
                    rd_rsp.data = mtimecmp_q;
                    rd_rsp.hit  = 1'b1;
                end
                MTIME_OFFSET:
                begin
                    rd_rsp.data = mtime;
                    rd_rsp.hit  = 1'b1;
                end
                default:
                begin
                    rd_rsp = '0;
                end
            endcase
        end
    end

    assign mtimecmp = mtimecmp_q;
    assign msip     = msip_q;

endmodule

`default_nettype wire

// ==== verilog/clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  clint_pkg::reg_wr_t            mtime_wr,
    input  logic [clint_pkg::MTIME_W-1:0] mtimecmp,
    output logic [clint_pkg::MTIME_W-1:0] mtime,
    output logic                          mtip
);
    import clint_pkg::*;

    logic [MTIME_W-1:0] mtime_q;
    logic               mtip_q;

    // free running, a write replaces the increment on that edge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtime_q <= '0;
        end
        else if (mtime_wr.en)
        begin
            mtime_q <= merge_bytes(mtime_q, mtime_wr.data, mtime_wr.strb);
        end
        else
        begin
            mtime_q <= mtime_q + MTIME_W'(1);
        end
    end

    // level interrupt, one cycle behind the unsigned compare
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtip_q <= 1'b0;
        end
        else
        begin
            mtip_q <= (mtime_q >= mtimecmp);
        end
    end

    assign mtime = mtime_q;
    assign mtip  = mtip_q;

endmodule

`default_nettype wire

// ==== verilog/clint_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  axi_lite_pkg::axi_aw_t aw,
    input  logic                  awvalid,
    output logic                  awready,
    input  axi_lite_pkg::axi_w_t  w,
    input  logic                  wvalid,
    output logic                  wready,
    output axi_lite_pkg::axi_b_t  b,
    output logic                  bvalid,
    input  logic                  bready,
    input  axi_lite_pkg::axi_ar_t ar,
    input  logic                  arvalid,
    output logic                  arready,
    output axi_lite_pkg::axi_r_t  r,
    output logic                  rvalid,
    input  logic                  rready,
    output logic                  mtip,
    output logic                  msip
);
    import clint_pkg::*;

    reg_wr_t            reg_wr;
    logic               wr_hit;
    reg_rd_t            reg_rd;
    reg_rd_rsp_t        rd_rsp;
    reg_wr_t            mtime_wr;
    logic [MTIME_W-1:0] mtime;
    logic [MTIME_W-1:0] mtimecmp;

    clint_axi_slave u_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .reg_wr  (reg_wr),
        .wr_hit  (wr_hit),
        .reg_rd  (reg_rd),
        .rd_rsp  (rd_rsp)
    );

    clint_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_wr   (reg_wr),
        .wr_hit   (wr_hit),
        .reg_rd   (reg_rd),
        .rd_rsp   (rd_rsp),
        .mtime    (mtime),
        .mtime_wr (mtime_wr),
        .mtimecmp (mtimecmp),
        .msip     (msip)
    );

    clint_timer u_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .mtime_wr (mtime_wr),
        .mtimecmp (mtimecmp),
        .mtime    (mtime),
        .mtip     (mtip)
    );

endmodule

`default_nettype wire
